//--- common/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// cache geometry
`define DCACHE_WAYS 4
`define DCACHE_SETS 16

// 32-bit beats per 64-byte line refill
`define DCACHE_BEATS 16

// everything at or above this address bypasses the cache
`define DCACHE_UNCACHED_BASE 32'h9000_0000

// behavioral main memory size, 32 KB
`define MEM_WORDS 8192

`endif

//--- common/dcache_pkg.sv
package dcache_pkg;

	// request address, either flat or split into cache fields
	typedef union packed {
		logic [31:0] word;
		struct packed {
			logic [21:0] tag;
			logic [3:0]  set;
			logic [1:0]  row;
			logic        dw;
			logic [2:0]  offset;
		} f;
	} dcache_addr_u;

	typedef enum logic [1:0] {
		idle,
		refill,
		uncached_read
	} dcache_state_e;

endpackage

//--- common/mem_bus_pkg.sv
package mem_bus_pkg;

	// one read burst beat
	typedef logic [31:0] mem_word_t;

	// beats minus one
	typedef logic [7:0] burst_len_t;

	// one bit per byte of a 64-bit write
	typedef logic [7:0] wr_strb_t;

endpackage

//--- common/mem_if.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

interface mem_if;
	logic [31:0]             araddr;
	mem_bus_pkg::burst_len_t arlen;
	logic                    arvalid;
	logic                    arready;
	mem_bus_pkg::mem_word_t  rdata;
	logic                    rvalid;
	logic                    rlast;
	logic                    wr_en;
	logic [31:0]             wr_addr;
	logic [63:0]             wr_data;
	mem_bus_pkg::wr_strb_t   wr_strb;

	modport master(output araddr, arlen, arvalid, wr_en, wr_addr, wr_data, wr_strb,
		input arready, rdata, rvalid, rlast);
	modport slave(input araddr, arlen, arvalid, wr_en, wr_addr, wr_data, wr_strb,
		output arready, rdata, rvalid, rlast);
endinterface

interface dc_lookup_if;
	dcache_pkg::dcache_addr_u  addr;
	logic                      fill_en;
	logic [`DCACHE_WAYS-1:0]   fill_way;
	logic                      inval_en;
	logic [`DCACHE_WAYS-1:0]   hit_way;

	modport ctrl(output addr, fill_en, fill_way, inval_en, input hit_way);
	modport tags(input addr, fill_en, fill_way, inval_en, output hit_way);
endinterface

//--- dcache/dcache_tag_array.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tag_array (
	input logic clk,
	input logic rst,
	dc_lookup_if.tags lk
);

	logic [21:0]               tags [`DCACHE_WAYS][`DCACHE_SETS];
	logic [`DCACHE_SETS-1:0]   vld [`DCACHE_WAYS];
	logic [`DCACHE_WAYS-1:0]   tag_eq;
	logic [`DCACHE_WAYS-1:0]   hit;

	// compare all ways of the addressed set at once
	always_comb begin
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			tag_eq[w] = (tags[w][lk.addr.f.set] == lk.addr.f.tag);
			hit[w] = vld[w][lk.addr.f.set] && tag_eq[w];
		end
	end

	assign lk.hit_way = hit;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `DCACHE_WAYS; w++) begin
				vld[w] <= '0;
			end
		end else begin
			for (int w = 0; w < `DCACHE_WAYS; w++) begin
				if (lk.fill_en && lk.fill_way[w]) begin
					vld[w][lk.addr.f.set] <= 1'b1;
				end else if (lk.inval_en && tag_eq[w]) begin
					// a write through drops any copy of its line
					vld[w][lk.addr.f.set] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			if (lk.fill_en && lk.fill_way[w]) begin
				tags[w][lk.addr.f.set] <= lk.addr.f.tag;
			end
		end
	end

	// lines are only filled on a miss, so one address never lives in two ways
	a_hit_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(lk.hit_way)
	);

endmodule

//--- dcache/dcache_data_array.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_data_array (
	input  logic                    clk,
	input  logic [`DCACHE_WAYS-1:0] way_en,
	input  logic [5:0]              row,
	input  logic                    wr_en,
	input  logic [1:0]              wr_lane,
	input  mem_bus_pkg::mem_word_t  wr_word,
	output logic [127:0]            rd_line
);

	localparam int ROWS = `DCACHE_SETS * 4;

	logic [`DCACHE_WAYS-1:0] sel_q;
	logic [127:0]            way_out [`DCACHE_WAYS];

	// one single-port ram per way
	for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
		logic [127:0] ram [ROWS];
		logic [127:0] rd_q;

		always_ff @(posedge clk) begin
			if (way_en[w]) begin
				if (wr_en) begin
					ram[row][wr_lane*32 +: 32] <= wr_word;
				end else begin
					rd_q <= ram[row];
				end
			end
		end

		assign way_out[w] = sel_q[w] ? rd_q : '0;
	end

	// remember which way was read last cycle
	always_ff @(posedge clk) begin
		sel_q <= way_en;
	end

	always_comb begin
		rd_line = '0;
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			rd_line = rd_line | way_out[w];
		end
	end

endmodule

//--- dcache/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    valid,
	input  logic                    wren,
	input  logic [31:0]             addr,
	input  logic [63:0]             din,
	input  logic [63:0]             mask,
	output logic                    ready,
	output logic [63:0]             dout,
	mem_if.master                   mem,
	dc_lookup_if.ctrl               lk,
	output logic [`DCACHE_WAYS-1:0] way_en,
	output logic [5:0]              row,
	output logic                    wr_en,
	output logic [1:0]              wr_lane,
	output mem_bus_pkg::mem_word_t  wr_word,
	input  logic [127:0]            rd_line
);

	localparam int CNT_W = $clog2(`DCACHE_BEATS);

	dcache_pkg::dcache_addr_u  addr_u;
	dcache_pkg::dcache_state_e state;
	logic [`DCACHE_WAYS-1:0]   ring;
	logic [`DCACHE_WAYS-1:0]   victim_q;
	logic [`DCACHE_WAYS-1:0]   hit_way_q;
	logic [CNT_W-1:0]          cnt;
	logic [63:0]               unc_q;
	mem_bus_pkg::wr_strb_t     strb;
	logic                      req;
	logic                      is_uc;
	logic                      hit;
	logic                      rd_hit;
	logic                      rd_miss;
	logic                      rd_unc;
	logic                      wr_req;
	logic                      ar_fire;
	logic                      fill_beat;

	assign addr_u.word = addr;
	assign is_uc = (addr_u.word >= `DCACHE_UNCACHED_BASE);
	assign hit = |lk.hit_way;

	// a new request is only taken in idle and never in the ready cycle
	assign req = (state == dcache_pkg::idle) && valid && !ready;
	assign rd_hit = req && !wren && !is_uc && hit;
	assign rd_miss = req && !wren && !is_uc && !hit;
	assign rd_unc = req && !wren && is_uc;
	assign wr_req = req && wren;
	assign ar_fire = mem.arvalid && mem.arready;
	assign fill_beat = (state == dcache_pkg::refill) && mem.rvalid;

	// a miss reads the full line and an uncached read one doubleword
	assign mem.arvalid = rd_miss || rd_unc;
	assign mem.araddr = rd_unc ? {addr_u.word[31:3], 3'b0} : {addr_u.word[31:6], 6'b0};
	assign mem.arlen = rd_unc ? 8'd1 : 8'(`DCACHE_BEATS - 1);

	// byte strobe from bit 0 of each mask byte
	always_comb begin
		for (int b = 0; b < 8; b++) begin
			strb[b] = mask[8*b];
		end
	end

	assign mem.wr_en = wr_req;
	assign mem.wr_addr = addr_u.word;
	assign mem.wr_data = din;
	assign mem.wr_strb = strb;

	assign lk.addr = addr_u;
	assign lk.inval_en = wr_req;
	assign lk.fill_en = fill_beat && mem.rlast;
	assign lk.fill_way = victim_q;

	// refill writes into the victim, a hit reads the matching way
	assign way_en = fill_beat ? victim_q : (rd_hit ? lk.hit_way : '0);
	assign wr_en = fill_beat;
	assign row = (state == dcache_pkg::refill) ? {addr_u.f.set, cnt[3:2]}
		: {addr_u.f.set, addr_u.f.row};
	assign wr_lane = cnt[1:0];
	assign wr_word = mem.rdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dcache_pkg::idle;
			ring <= `DCACHE_WAYS'(1);
			victim_q <= '0;
			hit_way_q <= '0;
			cnt <= '0;
			ready <= 1'b0;
		end else begin
			ready <= rd_hit || wr_req
				|| ((state == dcache_pkg::uncached_read) && mem.rvalid && mem.rlast);
			hit_way_q <= rd_hit ? lk.hit_way : '0;
			case (state)
				dcache_pkg::idle: begin
					ring <= {ring[`DCACHE_WAYS-2:0], ring[`DCACHE_WAYS-1]};
					cnt <= '0;
					if (ar_fire) begin
						victim_q <= ring;
						state <= rd_unc ? dcache_pkg::uncached_read : dcache_pkg::refill;
					end
				end
				default: begin
					if (mem.rvalid) begin
						cnt <= cnt + 1'b1;
						if (mem.rlast) begin
							state <= dcache_pkg::idle;
						end
					end
				end
			endcase
		end
	end

	// low word of the uncached doubleword arrives first
	always_ff @(posedge clk) begin
		if ((state == dcache_pkg::uncached_read) && mem.rvalid) begin
			unc_q[cnt[0]*32 +: 32] <= mem.rdata;
		end
	end

	assign dout = (|hit_way_q) ? (addr_u.f.dw ? rd_line[127:64] : rd_line[63:0]) : unc_q;

	// the tag is only written once every beat of the line is in
	a_fill_full_line: assert property (
		@(posedge clk) disable iff (rst)
		lk.fill_en |-> (cnt == CNT_W'(`DCACHE_BEATS - 1))
	);

	a_ready_pulse: assert property (
		@(posedge clk) disable iff (rst)
		ready |=> !ready
	);

endmodule

//--- verilog/main_mem.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module main_mem (
	input logic clk,
	input logic rst,
	mem_if.slave bus
);

	localparam int IDX_W = $clog2(`MEM_WORDS);

	mem_bus_pkg::mem_word_t  mem [`MEM_WORDS];
	logic                    busy;
	logic                    wait_q;
	logic                    emit;
	logic [IDX_W-1:0]        ptr;
	logic [IDX_W-1:0]        wr_idx;
	mem_bus_pkg::burst_len_t remain;

	// low half backs the cached window, high half the uncached one
	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			logic [31:0] base;
			base = (i < `MEM_WORDS / 2) ? 32'h8000_0000 : `DCACHE_UNCACHED_BASE;
			mem[i] = (base | (32'(i) << 2)) ^ 32'h5A5A_0000;
		end
	end

	assign bus.arready = !busy;
	// first beat one cycle after the wait, then back to back
	assign emit = wait_q || (bus.rvalid && !bus.rlast);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			wait_q <= 1'b0;
			bus.rvalid <= 1'b0;
			bus.rlast <= 1'b0;
		end else begin
			wait_q <= bus.arvalid && bus.arready;
			if (bus.arvalid && bus.arready) begin
				busy <= 1'b1;
			end else if (bus.rvalid && bus.rlast) begin
				busy <= 1'b0;
			end
			bus.rvalid <= emit;
			bus.rlast <= emit && (remain == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (bus.arvalid && bus.arready) begin
			ptr <= bus.araddr[IDX_W+1:2];
			remain <= bus.arlen;
		end else if (emit) begin
			bus.rdata <= mem[ptr];
			ptr <= ptr + 1'b1;
			remain <= remain - 1'b1;
		end
	end

	assign wr_idx = {bus.wr_addr[IDX_W+1:3], 1'b0};

	always @(posedge clk) begin
		if (bus.wr_en) begin
			for (int b = 0; b < 4; b++) begin
				if (bus.wr_strb[b])
					mem[wr_idx][8*b +: 8] <= bus.wr_data[8*b +: 8];
				if (bus.wr_strb[b+4])
					mem[wr_idx + 1'b1][8*b +: 8] <= bus.wr_data[32 + 8*b +: 8];
			end
		end
	end

	a_rvalid_in_burst: assert property (
		@(posedge clk) disable iff (rst)
		bus.rvalid |-> busy
	);

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module cache_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        valid,
	input  logic        wren,
	input  logic [31:0] addr,
	input  logic [63:0] din,
	input  logic [63:0] mask,
	output logic        ready,
	output logic [63:0] dout
);

	logic [`DCACHE_WAYS-1:0] way_en;
	logic [5:0]              row;
	logic                    wr_en;
	logic [1:0]              wr_lane;
	mem_bus_pkg::mem_word_t  wr_word;
	logic [127:0]            rd_line;

	mem_if       mem_bus ();
	dc_lookup_if lk ();

	dcache_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.valid(valid), .wren(wren), .addr(addr), .din(din), .mask(mask),
		.ready(ready), .dout(dout),
		.mem(mem_bus.master), .lk(lk.ctrl),
		.way_en(way_en), .row(row), .wr_en(wr_en),
		.wr_lane(wr_lane), .wr_word(wr_word), .rd_line(rd_line)
	);

	dcache_tag_array u_tags (.clk(clk), .rst(rst), .lk(lk.tags));

	dcache_data_array u_data (
		.clk(clk), .way_en(way_en), .row(row), .wr_en(wr_en),
		.wr_lane(wr_lane), .wr_word(wr_word), .rd_line(rd_line)
	);

	main_mem u_mem (.clk(clk), .rst(rst), .bus(mem_bus.slave));

endmodule

//--- testbench/tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top;

	localparam int CLK_PERIOD = 4;
	localparam int SEED = 53165;
	localparam int RAND_OPS = 300;
	// 26 directed requests plus the random phase
	localparam int OPS = 26 + RAND_OPS;

	localparam logic [31:0] COLD_ADDR [5] = '{
		32'h8000_0000, 32'h8000_0138, 32'h8000_0A48, 32'h8000_2A40, 32'h8000_3FF8
	};

	logic        clk;
	logic        rst;
	logic        valid;
	logic        wren;
	logic [31:0] addr;
	logic [63:0] din;
	logic [63:0] mask;
	logic        ready;
	logic [63:0] dout;

	// expectations of requests still waiting for ready
	string       exp_name [$];
	logic [63:0] exp_data [$];
	bit          exp_read [$];

	// words written so far, keyed by word address
	logic [31:0] shadow [logic [31:0]];

	cache_top dut (
		.clk(clk), .rst(rst),
		.valid(valid), .wren(wren), .addr(addr), .din(din), .mask(mask),
		.ready(ready), .dout(dout)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("Mismatch in %s: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	// untouched memory holds its own address xor 0x5a5a0000
	function automatic logic [31:0] word_ref(input logic [31:0] wa);
		if (shadow.exists(wa)) begin
			return shadow[wa];
		end
		return wa ^ 32'h5A5A_0000;
	endfunction

	function automatic logic [63:0] dword_ref(input logic [31:0] a);
		return {word_ref({a[31:3], 3'b100}), word_ref({a[31:3], 3'b000})};
	endfunction

	// byte b is written when bit 0 of mask byte b is set
	task automatic shadow_write(input logic [31:0] a, input logic [63:0] d,
		input logic [63:0] m);
		logic [31:0] lo_a;
		logic [31:0] hi_a;
		logic [31:0] lo;
		logic [31:0] hi;
		lo_a = {a[31:3], 3'b000};
		hi_a = lo_a + 32'd4;
		lo = word_ref(lo_a);
		hi = word_ref(hi_a);
		for (int b = 0; b < 4; b++) begin
			if (m[8*b])
				lo[8*b +: 8] = d[8*b +: 8];
			if (m[32 + 8*b])
				hi[8*b +: 8] = d[32 + 8*b +: 8];
		end
		shadow[lo_a] = lo;
		shadow[hi_a] = hi;
	endtask

	// called on a falling edge, returns on a falling edge
	task automatic issue(input string name, input bit wr, input logic [31:0] a,
		input logic [63:0] d, input logic [63:0] m, output int lat);
		if (wr)
			shadow_write(a, d, m);
		exp_name.push_back(name);
		exp_data.push_back(wr ? 64'h0 : dword_ref(a));
		exp_read.push_back(!wr);
		valid = 1'b1;
		wren = wr;
		addr = a;
		din = d;
		mask = m;
		lat = 0;
		do begin
			@(posedge clk);
			lat++;
		end while (!ready);
		// ready is seen one edge after the edge that raised it
		lat--;
		@(negedge clk);
		valid = 1'b0;
		wren = 1'b0;
	endtask

	task automatic read_op(input string name, input logic [31:0] a, output int lat);
		issue(name, 1'b0, a, 64'h0, 64'h0, lat);
	endtask

	// every ready pulse retires the oldest request
	always @(posedge clk) begin : compare_proc
		string       name;
		logic [63:0] expected;
		bit          is_read;
		if (!rst && ready) begin
			if (exp_name.size() == 0) begin
				abort_run("ready pulse arrived with no request outstanding");
			end else begin
				name = exp_name.pop_front();
				expected = exp_data.pop_front();
				is_read = exp_read.pop_front();
				if (is_read)
					check_value(name, expected, dout);
			end
		end
	end

	initial begin
		#(OPS * 40 * CLK_PERIOD);
		abort_run("watchdog timeout, the requests did not complete in time");
	end

	initial begin
		int          lat;
		int unsigned seed;
		logic [31:0] a;
		logic [63:0] d;
		logic [63:0] m;
		logic [7:0]  strb;
		bit          wr;
		seed = SEED;
		void'($urandom(seed));
		clk = 1'b0;
		rst = 1'b1;
		valid = 1'b0;
		wren = 1'b0;
		addr = '0;
		din = '0;
		mask = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// cold reads, each line distinct so each one misses
		for (int i = 0; i < 5; i++) begin
			read_op($sformatf("cold_read_%0d", i), COLD_ADDR[i], lat);
			check_value($sformatf("cold_read_%0d latency above 1", i), 1, lat > 1);
		end

		// other doubleword of a freshly filled line
		read_op("repeat_read_miss", 32'h8000_0510, lat);
		read_op("repeat_read_hit", 32'h8000_0518, lat);
		check_value("repeat_read_hit latency", 1, lat);

		// masked write over a cached line, then read back twice
		read_op("merge_prefill", 32'h8000_0228, lat);
		issue("merge_write", 1'b1, 32'h8000_0228, 64'h1122_3344_5566_7788,
			64'h00FF_FE01_0000_FFFF, lat);
		check_value("merge_write latency", 1, lat);
		read_op("merge_read", 32'h8000_0228, lat);
		read_op("merge_reread", 32'h8000_0228, lat);
		check_value("merge_reread latency", 1, lat);

		// six lines of set 2 in four ways
		for (int r = 0; r < 2; r++) begin
			for (int k = 0; k < 6; k++) begin
				a = 32'h8000_0080 + 32'(k) * 32'h400 + 32'(k) * 8;
				read_op($sformatf("set_conflict_r%0d_k%0d", r, k), a, lat);
			end
		end

		// uncached reads never allocate
		read_op("uncached_read_0", 32'h9000_4100, lat);
		read_op("uncached_read_1", 32'h9000_7FF8, lat);
		read_op("uncached_reread", 32'h9000_4100, lat);
		check_value("uncached_reread latency above 1", 1, lat > 1);

		// 4 KB of the cached window gives both hits and evictions
		for (int i = 0; i < RAND_OPS; i++) begin
			if (($urandom % 10) < 7)
				a = 32'h8000_0000 + (($urandom % 64) << 6) + (($urandom % 8) << 3);
			else
				a = 32'h9000_4000 + (($urandom % 2048) << 3);
			wr = (($urandom % 10) < 4);
			d = {$urandom, $urandom};
			strb = 8'($urandom);
			for (int b = 0; b < 8; b++) begin
				m[8*b +: 8] = strb[b] ? 8'hFF : 8'h00;
			end
			issue($sformatf("random_%0d", i), wr, a, d, m, lat);
		end

		repeat (2) @(negedge clk);
		if (exp_name.size() != 0) begin
			abort_run("some requests never received a ready pulse");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

//--- tb.f
+incdir+common
common/dcache_pkg.sv
common/mem_bus_pkg.sv
common/mem_if.sv
dcache/dcache_tag_array.sv
dcache/dcache_data_array.sv
dcache/dcache_ctrl.sv
verilog/main_mem.sv
verilog/cache_top.sv
testbench/tb_cache_top.sv
